// File: include/core_version.svh
//////////////////////////////////////////////////////////////////////
// core version words for readback
//////////////////////////////////////////////////////////////////////
`ifndef CORE_VERSION_SVH
`define CORE_VERSION_SVH

// compat number, major AC and minor 0B
`define CORE_COMPAT 32'hAC000B00

// build hash, a build script can redefine this after the include
`define CORE_GIT_HASH 32'h0123abcd

`endif

// File: verilog/core_regs_pkg.sv
//////////////////////////////////////////////////////////////////////
// core register map
// settings write addresses and readback select codes
//////////////////////////////////////////////////////////////////////
package core_regs_pkg;

  // settings bus write addresses
  localparam logic [10:0] SR_READBACK = 11'd0;
  localparam logic [10:0] SR_MISC     = 11'd4;
  localparam logic [10:0] SR_TEST     = 11'd28;
  localparam logic [10:0] SR_XB_LOCAL = 11'd32;

  // readback select codes
  localparam logic [4:0] RB_MISC     = 5'd1;
  localparam logic [4:0] RB_COMPAT   = 5'd2;
  localparam logic [4:0] RB_GITHASH  = 5'd3;
  localparam logic [4:0] RB_PLL      = 5'd4;
  localparam logic [4:0] RB_XB_LOCAL = 5'd6;
  localparam logic [4:0] RB_TEST     = 5'd24;

  // returned for any code not in the map
  localparam logic [31:0] RB_DEFAULT = 32'hdeadbeef;

  // pps_select 2'b10 picks the internal pps
  localparam logic [31:0] MISC_RESET     = 32'h2;
  localparam logic [7:0]  XB_LOCAL_RESET = 8'd40;

  // one-hot select, at most one bit per write
  typedef struct packed {
    logic readback;
    logic misc;
    logic test;
    logic xb_local;
  } reg_sel_t;

endpackage

// File: verilog/core_fields_pkg.sv
//////////////////////////////////////////////////////////////////////
// core field layouts
// settings bus bundle and the misc control word fields
//////////////////////////////////////////////////////////////////////
package core_fields_pkg;

  localparam int SET_AWIDTH = 11;

  // one settings bus beat
  typedef struct packed {
    logic                  stb;
    logic [SET_AWIDTH-1:0] addr;
    logic [31:0]           data;
  } set_bus_t;

  // misc word, msb first
  typedef struct packed {
    logic [10:0] spare;
    logic [3:0]  rx_bandsel_c;
    logic [3:0]  rx_bandsel_b;
    logic [5:0]  rx_bandsel_a;
    logic [2:0]  tx_bandsel;
    logic        codec_arst;
    logic        mimo;
    logic [1:0]  pps_select;
  } misc_fields_t;

  // stored as a raw word, read back as fields
  typedef union packed {
    logic [31:0]  raw;
    misc_fields_t f;
  } misc_word_u;

endpackage

// File: verilog/set_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// settings address decode
// registers each write and turns its address into a register select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module set_addr_decode
  import core_regs_pkg::*, core_fields_pkg::*;
#(
  parameter int AWIDTH = 11
) (
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  set_bus_t    i_set,
  output reg_sel_t    o_sel,
  output logic [31:0] o_data
);

  // bus bundle carries a fixed address width
  if (AWIDTH != SET_AWIDTH) begin : g_awidth_check
    $error("set_addr_decode: AWIDTH must match the settings bus address width");
  end

  logic [AWIDTH-1:0] addr;

  assign addr = i_set.addr[AWIDTH-1:0];

  // select is a one-cycle pulse per matching strobe
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_sel <= '0;
    end else begin
      o_sel.readback <= i_set.stb && (addr == SR_READBACK[AWIDTH-1:0]);
      o_sel.misc     <= i_set.stb && (addr == SR_MISC[AWIDTH-1:0]);
      o_sel.test     <= i_set.stb && (addr == SR_TEST[AWIDTH-1:0]);
      o_sel.xb_local <= i_set.stb && (addr == SR_XB_LOCAL[AWIDTH-1:0]);
    end
  end

  // data only moves with a strobe
  always_ff @(posedge bus_clk) begin
    if (i_set.stb) begin
      o_data <= i_set.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // map addresses are distinct, so never two selects at once
  a_sel_onehot: assert property (
    @(posedge bus_clk) disable iff (bus_rst) $onehot0(o_sel)
  );

endmodule

// File: verilog/setting_reg.sv
//////////////////////////////////////////////////////////////////////
// setting register, loads on a decoded select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module setting_reg #(
  parameter int               WIDTH    = 32,
  parameter logic [WIDTH-1:0] AT_RESET = '0
) (
  input  logic             bus_clk,
  input  logic             bus_rst,
  input  logic             i_load,
  input  logic [WIDTH-1:0] i_data,
  output logic [WIDTH-1:0] o_value,
  output logic             o_changed
);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_value   <= AT_RESET;
      o_changed <= 1'b0;
    end else begin
      // pulse only when a load actually moves the value
      o_changed <= i_load && (i_data != o_value);
      if (i_load) begin
        o_value <= i_data;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // no load, no change on the next cycle
  a_hold: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
      !i_load && !bus_rst |=> $stable(o_value)
  );

endmodule

// File: verilog/core_readback.sv
//////////////////////////////////////////////////////////////////////
// core readback
// syncs the pll lock bits and muxes the selected status word
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "core_version.svh"

module core_readback
  import core_regs_pkg::*, core_fields_pkg::*;
(
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic [4:0]  i_rb_sel,
  input  misc_word_u  i_misc,
  input  logic [31:0] i_test,
  input  logic [7:0]  i_xb_local,
  input  logic [3:0]  i_tcxo_status,
  input  logic [1:0]  i_lock_signals,
  output logic [31:0] o_rb_data
);

  logic [1:0] lock_meta;
  logic [1:0] lock_sync;

  //////////////////////////////////////////////////////////////////////
  // pll lock synchronizer
  //////////////////////////////////////////////////////////////////////

  // lock bits come from the radio side, two flops
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_rb_sel)
      RB_MISC:     o_rb_data = {26'd0, i_tcxo_status, i_misc.f.pps_select};
      RB_COMPAT:   o_rb_data = `CORE_COMPAT;
      RB_GITHASH:  o_rb_data = `CORE_GIT_HASH;
      RB_PLL:      o_rb_data = {30'd0, lock_sync};
      RB_XB_LOCAL: o_rb_data = {24'd0, i_xb_local};
      RB_TEST:     o_rb_data = i_test;
      default:     o_rb_data = RB_DEFAULT;
    endcase
  end

  // every register feeding the mux must come out of reset known
  a_rb_known: assert property (
    @(posedge bus_clk) disable iff (bus_rst) !$isunknown(o_rb_data)
  );

endmodule

// File: verilog/core_regs_top.sv
//////////////////////////////////////////////////////////////////////
// core register block top
// settings decode, setting registers, readback and misc outputs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module core_regs_top
  import core_regs_pkg::*, core_fields_pkg::*;
#(
  parameter int AWIDTH = 11
) (
  input  logic              bus_clk,
  input  logic              bus_rst,
  input  logic              i_set_stb,
  input  logic [AWIDTH-1:0] i_set_addr,
  input  logic [31:0]       i_set_data,
  input  logic [3:0]        i_tcxo_status,
  input  logic [1:0]        i_lock_signals,
  output logic [31:0]       o_rb_data,
  output logic [1:0]        o_pps_select,
  output logic              o_mimo,
  output logic              o_codec_arst,
  output logic [2:0]        o_tx_bandsel,
  output logic [5:0]        o_rx_bandsel_a,
  output logic [3:0]        o_rx_bandsel_b,
  output logic [3:0]        o_rx_bandsel_c,
  output logic [7:0]        o_xb_local_addr
);

  set_bus_t    set_bus;
  reg_sel_t    sel;
  logic [31:0] set_data_q;
  logic [4:0]  rb_sel;
  misc_word_u  misc;
  logic [31:0] test_word;

  assign set_bus.stb  = i_set_stb;
  assign set_bus.addr = i_set_addr;
  assign set_bus.data = i_set_data;

  set_addr_decode #(.AWIDTH(AWIDTH)) u_decode (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_set   (set_bus),
    .o_sel   (sel),
    .o_data  (set_data_q)
  );

  //////////////////////////////////////////////////////////////////////
  // setting registers
  //////////////////////////////////////////////////////////////////////

  setting_reg #(.WIDTH(5), .AT_RESET(5'd0)) u_sr_readback (
    .bus_clk (bus_clk), .bus_rst (bus_rst),
    .i_load  (sel.readback), .i_data (set_data_q[4:0]),
    .o_value (rb_sel), .o_changed ()
  );

  setting_reg #(.WIDTH(32), .AT_RESET(MISC_RESET)) u_sr_misc (
    .bus_clk (bus_clk), .bus_rst (bus_rst),
    .i_load  (sel.misc), .i_data (set_data_q),
    .o_value (misc.raw), .o_changed ()
  );

  setting_reg #(.WIDTH(32), .AT_RESET(32'h0)) u_sr_test (
    .bus_clk (bus_clk), .bus_rst (bus_rst),
    .i_load  (sel.test), .i_data (set_data_q),
    .o_value (test_word), .o_changed ()
  );

  // crossbar local address, kept for the crossbar outside this block
  setting_reg #(.WIDTH(8), .AT_RESET(XB_LOCAL_RESET)) u_sr_xb_local (
    .bus_clk (bus_clk), .bus_rst (bus_rst),
    .i_load  (sel.xb_local), .i_data (set_data_q[7:0]),
    .o_value (o_xb_local_addr), .o_changed ()
  );

  // misc fields straight to the pins
  assign o_pps_select   = misc.f.pps_select;
  assign o_mimo         = misc.f.mimo;
  assign o_codec_arst   = misc.f.codec_arst;
  assign o_tx_bandsel   = misc.f.tx_bandsel;
  assign o_rx_bandsel_a = misc.f.rx_bandsel_a;
  assign o_rx_bandsel_b = misc.f.rx_bandsel_b;
  assign o_rx_bandsel_c = misc.f.rx_bandsel_c;

  core_readback u_readback (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .i_rb_sel       (rb_sel),
    .i_misc         (misc),
    .i_test         (test_word),
    .i_xb_local     (o_xb_local_addr),
    .i_tcxo_status  (i_tcxo_status),
    .i_lock_signals (i_lock_signals),
    .o_rb_data      (o_rb_data)
  );

endmodule

// File: dv/core_regs_tb.sv
//////////////////////////////////////////////////////////////////////
// core register block testbench
// random settings writes checked against a cycle model of the block
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module core_regs_tb import core_regs_pkg::*; ();

  localparam int N_TEST  = 20;
  localparam int N_BURST = 8;
  localparam int N_MISC  = 16;
  localparam int N_LOCK  = 24;
  localparam int N_XB    = 8;
  // rough cycle budget of the whole sequence doubled for margin
  localparam int TEST_CYCLES = 8 + 3 + 2*N_TEST + N_BURST + 3 + 3*N_MISC + 20
                               + 3 + N_LOCK + 15 + 3*N_XB + 10;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic        bus_clk;
  logic        bus_rst;
  logic        i_set_stb;
  logic [10:0] i_set_addr;
  logic [31:0] i_set_data;
  logic [3:0]  i_tcxo_status;
  logic [1:0]  i_lock_signals;
  logic [31:0] o_rb_data;
  logic [1:0]  o_pps_select;
  logic        o_mimo;
  logic        o_codec_arst;
  logic [2:0]  o_tx_bandsel;
  logic [5:0]  o_rx_bandsel_a;
  logic [3:0]  o_rx_bandsel_b;
  logic [3:0]  o_rx_bandsel_c;
  logic [7:0]  o_xb_local_addr;

  // model state
  logic        pend_stb;
  logic [10:0] pend_addr;
  logic [31:0] pend_data;
  logic [4:0]  m_rb_sel;
  logic [31:0] m_misc;
  logic [31:0] m_test;
  logic [7:0]  m_xb;
  logic [1:0]  m_lock1;
  logic [1:0]  m_lock2;

  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  logic   check_en;

  core_regs_top #(.AWIDTH(11)) u_core_regs_top (
    .bus_clk         (bus_clk),
    .bus_rst         (bus_rst),
    .i_set_stb       (i_set_stb),
    .i_set_addr      (i_set_addr),
    .i_set_data      (i_set_data),
    .i_tcxo_status   (i_tcxo_status),
    .i_lock_signals  (i_lock_signals),
    .o_rb_data       (o_rb_data),
    .o_pps_select    (o_pps_select),
    .o_mimo          (o_mimo),
    .o_codec_arst    (o_codec_arst),
    .o_tx_bandsel    (o_tx_bandsel),
    .o_rx_bandsel_a  (o_rx_bandsel_a),
    .o_rx_bandsel_b  (o_rx_bandsel_b),
    .o_rx_bandsel_c  (o_rx_bandsel_c),
    .o_xb_local_addr (o_xb_local_addr)
  );

  always #4 bus_clk = ~bus_clk;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_rb(input logic [4:0] sel,
                                              input logic [31:0] misc,
                                              input logic [31:0] test,
                                              input logic [7:0] xb,
                                              input logic [3:0] tcxo,
                                              input logic [1:0] lock);
    logic [31:0] word;
    case (sel)
      RB_MISC:     word = {26'd0, tcxo, misc[1:0]};
      RB_COMPAT:   word = 32'hAC000B00;
      RB_GITHASH:  word = 32'h0123abcd;
      RB_PLL:      word = {30'd0, lock};
      RB_XB_LOCAL: word = {24'd0, xb};
      RB_TEST:     word = test;
      default:     word = 32'hdeadbeef;
    endcase
    return word;
  endfunction

  // a strobe at edge N lands in the register at edge N+1
  always @(posedge bus_clk) begin
    if (bus_rst) begin
      pend_stb <= 1'b0;
      m_rb_sel <= 5'd0;
      m_misc   <= 32'h2;
      m_test   <= 32'h0;
      m_xb     <= 8'd40;
      m_lock1  <= 2'b00;
      m_lock2  <= 2'b00;
    end else begin
      pend_stb  <= i_set_stb;
      pend_addr <= i_set_addr;
      pend_data <= i_set_data;
      if (pend_stb) begin
        case (pend_addr)
          SR_READBACK: m_rb_sel <= pend_data[4:0];
          SR_MISC:     m_misc <= pend_data;
          SR_TEST:     m_test <= pend_data;
          SR_XB_LOCAL: m_xb <= pend_data[7:0];
          default:     ;
        endcase
      end
      m_lock1 <= i_lock_signals;
      m_lock2 <= m_lock1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  // misc fields sit at pps 1:0 mimo 2 codec 3 tx 6:4 rx_a 12:7 rx_b 16:13 rx_c 20:17
  task automatic compare_outputs();
    logic [31:0] exp_rb;
    exp_rb = expected_rb(m_rb_sel, m_misc, m_test, m_xb, i_tcxo_status, m_lock2);
    checks += 9;
    if (o_rb_data !== exp_rb) report_mismatch("o_rb_data", o_rb_data, exp_rb);
    if (o_pps_select !== m_misc[1:0])
      report_mismatch("o_pps_select", 32'(o_pps_select), 32'(m_misc[1:0]));
    if (o_mimo !== m_misc[2])
      report_mismatch("o_mimo", 32'(o_mimo), 32'(m_misc[2]));
    if (o_codec_arst !== m_misc[3])
      report_mismatch("o_codec_arst", 32'(o_codec_arst), 32'(m_misc[3]));
    if (o_tx_bandsel !== m_misc[6:4])
      report_mismatch("o_tx_bandsel", 32'(o_tx_bandsel), 32'(m_misc[6:4]));
    if (o_rx_bandsel_a !== m_misc[12:7])
      report_mismatch("o_rx_bandsel_a", 32'(o_rx_bandsel_a), 32'(m_misc[12:7]));
    if (o_rx_bandsel_b !== m_misc[16:13])
      report_mismatch("o_rx_bandsel_b", 32'(o_rx_bandsel_b), 32'(m_misc[16:13]));
    if (o_rx_bandsel_c !== m_misc[20:17])
      report_mismatch("o_rx_bandsel_c", 32'(o_rx_bandsel_c), 32'(m_misc[20:17]));
    if (o_xb_local_addr !== m_xb)
      report_mismatch("o_xb_local_addr", 32'(o_xb_local_addr), 32'(m_xb));
  endtask

  // sample midway through the high phase
  always begin
    @(posedge bus_clk);
    #2;
    if (check_en) compare_outputs();
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [10:0] addr, input logic [31:0] data);
    @(negedge bus_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge bus_clk);
      i_set_stb = 1'b0;
    end
  endtask

  task automatic select_rb(input logic [4:0] code);
    write_reg(SR_READBACK, {27'd0, code});
    idle(2);
  endtask

  task automatic check_rb(input logic [31:0] exp);
    @(posedge bus_clk);
    #2;
    checks++;
    if (o_rb_data !== exp) report_mismatch("o_rb_data", o_rb_data, exp);
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge bus_clk);
      cycles++;
    end
    $display("timeout: no end of test after %0d cycles, errors %0d", cycles, errors);
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    seed           = 32'h830d;
    errors         = 0;
    checks         = 0;
    check_en       = 1'b0;
    bus_clk        = 1'b0;
    bus_rst        = 1'b1;
    i_set_stb      = 1'b0;
    i_set_addr     = 11'd0;
    i_set_data     = 32'd0;
    i_tcxo_status  = 4'd0;
    i_lock_signals = 2'b00;
    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst  = 1'b0;
    check_en = 1'b1;

    // values straight out of reset
    @(posedge bus_clk);
    #2;
    checks += 5;
    if (o_pps_select !== 2'b10) report_mismatch("o_pps_select", 32'(o_pps_select), 32'h2);
    if (o_mimo !== 1'b0) report_mismatch("o_mimo", 32'(o_mimo), 32'h0);
    if (o_codec_arst !== 1'b0)
      report_mismatch("o_codec_arst", 32'(o_codec_arst), 32'h0);
    if (o_xb_local_addr !== 8'd40)
      report_mismatch("o_xb_local_addr", 32'(o_xb_local_addr), 32'd40);
    if (o_rb_data !== 32'hdeadbeef) report_mismatch("o_rb_data", o_rb_data, 32'hdeadbeef);

    // test register writes spaced then back to back
    select_rb(RB_TEST);
    for (int i = 0; i < N_TEST; i++) begin
      rnd = $random(seed);
      write_reg(SR_TEST, rnd);
      idle(1);
    end
    for (int i = 0; i < N_BURST; i++) begin
      rnd = $random(seed);
      write_reg(SR_TEST, rnd);
    end
    idle(2);

    // misc word with changing tcxo status
    select_rb(RB_MISC);
    for (int i = 0; i < N_MISC; i++) begin
      rnd = $random(seed);
      write_reg(SR_MISC, rnd);
      i_tcxo_status = rnd[27:24];
      idle(2);
    end

    // unmapped writes and readback codes
    select_rb(RB_TEST);
    write_reg(SR_TEST, 32'h5a5a0f0f);
    idle(1);
    write_reg(11'd8, $random(seed));
    write_reg(11'd1, $random(seed));
    write_reg(11'h7ff, $random(seed));
    idle(2);
    check_rb(32'h5a5a0f0f);
    select_rb(5'd5);
    check_rb(32'hdeadbeef);
    select_rb(5'd31);
    check_rb(32'hdeadbeef);

    // pll lock through the two flop sync
    select_rb(RB_PLL);
    for (int i = 0; i < N_LOCK; i++) begin
      rnd = $random(seed);
      @(negedge bus_clk);
      i_lock_signals = rnd[1:0];
    end
    idle(3);

    // constants and crossbar local address
    select_rb(RB_COMPAT);
    check_rb(32'hAC000B00);
    select_rb(RB_GITHASH);
    check_rb(32'h0123abcd);
    select_rb(RB_XB_LOCAL);
    for (int i = 0; i < N_XB; i++) begin
      rnd = $random(seed);
      write_reg(SR_XB_LOCAL, rnd);
      idle(2);
    end
    idle(3);

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
verilog/core_regs_pkg.sv
verilog/core_fields_pkg.sv
verilog/set_addr_decode.sv
verilog/setting_reg.sv
verilog/core_readback.sv
verilog/core_regs_top.sv
dv/core_regs_tb.sv

// File: Makefile
# Verilator build and run for the core register block

VERILATOR  ?= verilator
TOP        ?= core_regs_tb
RTL_TOP    ?= core_regs_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Iinclude verilog/core_regs_pkg.sv verilog/core_fields_pkg.sv \
	  verilog/set_addr_decode.sv verilog/setting_reg.sv verilog/core_readback.sv \
	  verilog/core_regs_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
